//--- Makefile
# Verilator flow for the capture target

VERILATOR ?= verilator
TOP       ?= capture_target_tb
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert
SIM_ARGS  ?= +verilator+error+limit+100
PASS_MSG  ?= No errors
SOURCES   := $(shell cat $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

sim: $(BUILD_DIR)/V$(TOP)
	@out="$$(./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

//--- list.f
rtl/capture_pkg.sv
rtl/cipher_start_if.sv
rtl/cmd_intake.sv
rtl/round_cipher.sv
rtl/result_port.sv
rtl/capture_target_top.sv
tests/clock_gen.sv
tests/capture_target_sva.sv
tests/capture_target_tb.sv

//--- rtl/capture_pkg.sv
// Capture target shared definitions
// Word types, host opcodes, cipher constants and FSM encodings
`default_nettype none

package capture_pkg;

  ////////////////////
  // Data types
  ////////////////////
  localparam int WORD_W = 32;

  typedef logic [WORD_W-1:0] word_t;   // Data, key or state word
  typedef logic [0:0]        op_t;     // Host opcode
  typedef logic [2:0]        round_t;  // Round index

  // Host opcodes
  localparam op_t OP_KEY   = 1'b0;  // Load key register
  localparam op_t OP_BLOCK = 1'b1;  // Encrypt one word

  // Cipher constants
  localparam int    NUM_ROUNDS  = 8;               // One round per clock
  localparam word_t ROUND_CONST = 32'h9e37_79b9;   // Scaled by round number + 1
  localparam int    ROT_AMOUNT  = 3;               // Left rotate per round

  ////////////////////
  // FSM encodings
  ////////////////////
  typedef enum logic [1:0] {
    INT_IDLE,       // Waiting for host req
    INT_ACK_KEY,    // Ack raised, key start cycle
    INT_ACK_BLOCK,  // Ack raised, block start cycle
    INT_WAIT_DROP   // Ack held until req falls
  } intake_state_t;

  typedef enum logic [1:0] {
    CIP_IDLE,
    CIP_RUN,   // Rounds in progress
    CIP_DONE   // Result held until taken
  } cipher_state_t;

  typedef enum logic [1:0] {
    RES_EMPTY,
    RES_REQ,       // Req high, word on the bus
    RES_WAIT_DROP  // Ack seen, waiting for it to fall
  } result_state_t;

endpackage : capture_pkg

`default_nettype wire

//--- rtl/capture_target_top.sv
// Capture target top level
// Host intake, round cipher and result port with a gated capture trigger
`timescale 1ns/1ps
`default_nettype none

module capture_target_top (
  input  wire logic                clk_main_i,
  input  wire logic                arst_n_i,
  // Host command port
  input  wire logic                host_req_i,
  input  wire capture_pkg::op_t    host_op_i,
  input  wire capture_pkg::word_t  host_data_i,
  output logic                     host_ack_o,
  // Host result port
  output logic                     res_req_o,
  output capture_pkg::word_t       res_data_o,
  input  wire logic                res_ack_i,
  // Scope trigger
  input  wire logic                trig_arm_i,
  output logic                     trig_o
);

  import capture_pkg::*;

  ////////////////////
  // Internal links
  ////////////////////
  cipher_start_if start_if ();

  logic  cipher_done;
  logic  cipher_running;
  logic  result_taken;
  word_t cipher_result;

  cmd_intake u_intake (
    .clk_main_i  ( clk_main_i  ),
    .arst_n_i    ( arst_n_i    ),
    .host_req_i  ( host_req_i  ),
    .host_op_i   ( host_op_i   ),
    .host_data_i ( host_data_i ),
    .host_ack_o  ( host_ack_o  ),
    .start       ( start_if    )
  );

  round_cipher u_cipher (
    .clk_main_i ( clk_main_i     ),
    .arst_n_i   ( arst_n_i       ),
    .start      ( start_if       ),
    .running_o  ( cipher_running ),  // Trigger gate
    .done_o     ( cipher_done    ),
    .result_o   ( cipher_result  ),
    .taken_i    ( result_taken   )
  );

  result_port u_result (
    .clk_main_i ( clk_main_i     ),
    .arst_n_i   ( arst_n_i       ),
    .done_i     ( cipher_done    ),
    .result_i   ( cipher_result  ),
    .taken_o    ( result_taken   ),
    .running_i  ( cipher_running ),
    .trig_arm_i ( trig_arm_i     ),
    .trig_o     ( trig_o         ),
    .res_req_o  ( res_req_o      ),
    .res_data_o ( res_data_o     ),
    .res_ack_i  ( res_ack_i      )
  );

endmodule : capture_target_top

`default_nettype wire

//--- rtl/cipher_start_if.sv
// Block start channel from the command intake to the round cipher
// Carries key loads and block starts, busy flows back
`timescale 1ns/1ps
`default_nettype none

interface cipher_start_if;

  import capture_pkg::*;

  logic  start;  // Single cycle pulse
  op_t   op;     // OP_KEY or OP_BLOCK
  word_t data;   // Key or plaintext
  logic  busy;   // Cipher in RUN or DONE

  // Intake side
  modport initiator (
    output start, op, data,
    input  busy
  );

  // Cipher side
  modport target (
    input  start, op, data,
    output busy
  );

endinterface : cipher_start_if

`default_nettype wire

//--- rtl/cmd_intake.sv
// Command intake
// Host four-phase req/ack, key loads and busy-gated block starts
`timescale 1ns/1ps
`default_nettype none

module cmd_intake (
  input  wire logic                clk_main_i,
  input  wire logic                arst_n_i,
  // Host port
  input  wire logic                host_req_i,
  input  wire capture_pkg::op_t    host_op_i,
  input  wire capture_pkg::word_t  host_data_i,
  output logic                     host_ack_o,
  // To cipher
  cipher_start_if.initiator        start
);

  import capture_pkg::*;

  intake_state_t state_q, state_d;
  word_t         data_q;  // Host word for the pending start

  ////////////////////
  // Handshake FSM
  ////////////////////
  always_comb begin
    state_d = state_q;
    unique case (state_q)
      INT_IDLE: begin
        if (host_req_i) begin
          if (host_op_i == OP_KEY) begin
            state_d = INT_ACK_KEY;  // Keys never wait
          end else if (!start.busy) begin
            state_d = INT_ACK_BLOCK;
          end
          // Block with busy high stays here, back-pressure
        end
      end
      INT_ACK_KEY,
      INT_ACK_BLOCK: begin
        state_d = INT_WAIT_DROP;  // Start lasts one cycle only
      end
      INT_WAIT_DROP: begin
        if (!host_req_i) begin
          state_d = INT_IDLE;  // Ack falls on next edge
        end
      end
      default: state_d = INT_IDLE;
    endcase
  end

  always_ff @(posedge clk_main_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= INT_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Sampled every idle cycle, frozen once accepted
  always_ff @(posedge clk_main_i) begin
    if (state_q == INT_IDLE) begin
      data_q <= host_data_i;
    end
  end

  // Outputs, all decoded from registered state
  assign host_ack_o = (state_q != INT_IDLE);
  assign start.start = (state_q == INT_ACK_KEY) || (state_q == INT_ACK_BLOCK);
  assign start.op    = (state_q == INT_ACK_KEY) ? OP_KEY : OP_BLOCK;
  assign start.data  = data_q;

endmodule : cmd_intake

`default_nettype wire

//--- rtl/result_port.sv
// Result port
// Holds the cipher output, runs the result req/ack and the capture trigger
`timescale 1ns/1ps
`default_nettype none

module result_port (
  input  wire logic                clk_main_i,
  input  wire logic                arst_n_i,
  // From cipher
  input  wire logic                done_i,
  input  wire capture_pkg::word_t  result_i,
  output logic                     taken_o,
  input  wire logic                running_i,
  // Trigger
  input  wire logic                trig_arm_i,
  output logic                     trig_o,
  // Host result port
  output logic                     res_req_o,
  output capture_pkg::word_t       res_data_o,
  input  wire logic                res_ack_i
);

  import capture_pkg::*;

  result_state_t state_q, state_d;
  word_t         data_q;  // Word shown to the host
  logic          load;    // Take result from cipher
  logic          trig_q;

  assign load = (state_q == RES_EMPTY) && done_i;

  ////////////////////
  // Handshake FSM
  ////////////////////
  always_comb begin
    state_d = state_q;
    unique case (state_q)
      RES_EMPTY:     if (load)       state_d = RES_REQ;
      RES_REQ:       if (res_ack_i)  state_d = RES_WAIT_DROP;  // Req falls
      RES_WAIT_DROP: if (!res_ack_i) state_d = RES_EMPTY;      // Phase 4 done
      default:                       state_d = RES_EMPTY;
    endcase
  end

  always_ff @(posedge clk_main_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= RES_EMPTY;
      trig_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      // Armed trigger passes only in active round cycles
      trig_q  <= trig_arm_i & running_i;
    end
  end

  // Stable for the whole req phase
  always_ff @(posedge clk_main_i) begin
    if (load) begin
      data_q <= result_i;
    end
  end

  assign taken_o    = load;  // Same cycle as the load
  assign res_req_o  = (state_q == RES_REQ);
  assign res_data_o = data_q;
  assign trig_o     = trig_q;

endmodule : result_port

`default_nettype wire

//--- rtl/round_cipher.sv
// Iterative round cipher
// Key register, state register and round counter, one round per clock
`timescale 1ns/1ps
`default_nettype none

module round_cipher (
  input  wire logic                clk_main_i,
  input  wire logic                arst_n_i,
  // From intake
  cipher_start_if.target           start,
  // To result port
  output logic                     running_o,
  output logic                     done_o,
  output capture_pkg::word_t       result_o,
  input  wire logic                taken_i
);

  import capture_pkg::*;

  cipher_state_t state_q, state_d;
  round_t        rnd_q;      // Current round index
  word_t         key_q;      // Last loaded key
  word_t         blk_key_q;  // Key snapshot, a key load mid-block leaves it intact
  word_t         blk_q;      // Cipher state word
  word_t         mixed;
  word_t         rotated;
  word_t         rc;
  word_t         round_out;
  logic          key_load;
  logic          blk_start;
  logic          last_round;

  assign key_load   = start.start && (start.op == OP_KEY);
  assign blk_start  = start.start && (start.op == OP_BLOCK) && (state_q == CIP_IDLE);
  assign last_round = (rnd_q == round_t'(NUM_ROUNDS - 1));

  ////////////////////
  // Round function
  ////////////////////
  assign mixed     = blk_q ^ blk_key_q;                                   // Key add
  assign rotated   = (mixed << ROT_AMOUNT) | (mixed >> (WORD_W - ROT_AMOUNT));
  assign rc        = ROUND_CONST * (word_t'(rnd_q) + word_t'(1));        // Const x (r+1)
  assign round_out = rotated + rc;                                        // Mod 2^32

  ////////////////////
  // Sequencer
  ////////////////////
  always_comb begin
    state_d = state_q;
    unique case (state_q)
      CIP_IDLE: if (blk_start)  state_d = CIP_RUN;
      CIP_RUN:  if (last_round) state_d = CIP_DONE;
      CIP_DONE: if (taken_i)    state_d = CIP_IDLE;  // Releases busy
      default:                  state_d = CIP_IDLE;
    endcase
  end

  always_ff @(posedge clk_main_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= CIP_IDLE;
      rnd_q   <= '0;
      key_q   <= '0;  // Zero key until first load
    end else begin
      state_q <= state_d;
      if (key_load) begin
        key_q <= start.data;
      end
      if (blk_start) begin
        rnd_q <= '0;
      end else if (state_q == CIP_RUN) begin
        rnd_q <= rnd_q + round_t'(1);  // Wraps to 0 after last round
      end
    end
  end

  // Datapath
  always_ff @(posedge clk_main_i) begin
    if (blk_start) begin
      blk_q     <= start.data;  // Plaintext in
      blk_key_q <= key_q;
    end else if (state_q == CIP_RUN) begin
      blk_q     <= round_out;
    end
  end

  assign start.busy = (state_q != CIP_IDLE);          // RUN or DONE
  assign running_o  = (state_q == CIP_RUN);           // Trigger gate
  assign done_o     = (state_q == CIP_DONE);          // Held until taken
  assign result_o   = blk_q ^ blk_key_q;              // Final whitening

endmodule : round_cipher

`default_nettype wire

//--- tests/capture_target_sva.sv
// Handshake and trigger assertions for the capture target
// Bound into the top level
`timescale 1ns/1ps
`default_nettype none

module capture_target_sva (
  input wire logic               clk_i,
  input wire logic               arst_n_i,
  input wire logic               host_req_i,
  input wire logic               host_ack_i,
  input wire logic               res_req_i,
  input wire capture_pkg::word_t res_data_i,
  input wire logic               res_ack_i,
  input wire logic               trig_arm_i,
  input wire logic               trig_i
);

  int unsigned fail_cnt;  // Failed assertion count

  initial fail_cnt = 0;

  // Ack only answers a pending req
  host_ack_needs_req: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    $rose(host_ack_i) |-> host_req_i)
    else begin
      fail_cnt++;
      $error("host_ack_o rose without host_req_i");
    end

  // Word frozen while offered, also in the cycle req falls
  res_data_held: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    res_req_i |=> $stable(res_data_i))
    else begin
      fail_cnt++;
      $error("res_data_o changed while res_req_o was high");
    end

  // Phase 4 must finish before a new req
  res_req_after_drop: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    $rose(res_req_i) |-> !res_ack_i)
    else begin
      fail_cnt++;
      $error("res_req_o rose while res_ack_i was high");
    end

  // Registered gate, so arm must lead by one cycle
  trig_needs_arm: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    trig_i |-> $past(trig_arm_i))
    else begin
      fail_cnt++;
      $error("trig_o high without trig_arm_i in the cycle before");
    end

endmodule : capture_target_sva

bind capture_target_top capture_target_sva u_sva (
  .clk_i      ( clk_main_i  ),
  .arst_n_i   ( arst_n_i    ),
  .host_req_i ( host_req_i  ),
  .host_ack_i ( host_ack_o  ),
  .res_req_i  ( res_req_o   ),
  .res_data_i ( res_data_o  ),
  .res_ack_i  ( res_ack_i   ),
  .trig_arm_i ( trig_arm_i  ),
  .trig_i     ( trig_o      )
);

`default_nettype wire

//--- tests/capture_target_tb.sv
// Capture target testbench
// Table-driven host and result models checked against a reference cipher model
`timescale 1ns/1ps
`default_nettype none

module capture_target_tb;

  import capture_pkg::*;

  typedef struct {
    op_t   op;
    word_t data;
    logic  arm;        // Trigger arm for a block
    int    ack_delay;  // Cycles res_ack_i is withheld
    word_t exp_data;   // Reference model result
    int    exp_trig;   // Expected trig_o cycles
  } stim_t;

  logic        clk_main;
  logic        arst_n;
  logic        host_req;
  op_t         host_op;
  word_t       host_data;
  logic        host_ack;
  logic        res_req;
  word_t       res_data;
  logic        res_ack;
  logic        trig_arm;
  logic        trig;
  stim_t       stim_q[$];
  logic [31:0] rng_state;
  logic        table_ready;
  int          n_acc;     // Blocks acked by the intake
  int          n_rcv;     // Results seen on the result port
  int          trig_cnt;  // trig_o cycles since the last result

  clock_gen u_clk (.clk_o(clk_main), .arst_n_o(arst_n));

  capture_target_top UUT (
    .clk_main_i  ( clk_main  ),
    .arst_n_i    ( arst_n    ),
    .host_req_i  ( host_req  ),
    .host_op_i   ( host_op   ),
    .host_data_i ( host_data ),
    .host_ack_o  ( host_ack  ),
    .res_req_o   ( res_req   ),
    .res_data_o  ( res_data  ),
    .res_ack_i   ( res_ack   ),
    .trig_arm_i  ( trig_arm  ),
    .trig_o      ( trig      )
  );

  ////////////////////
  // Helpers
  ////////////////////
  function automatic logic [31:0] next_random();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;  // Numerical Recipes LCG
    return rng_state;
  endfunction

  // Reference model of the toy block cipher
  function automatic word_t encrypt_ref(input word_t key, input word_t pt);
    word_t       s;
    logic [63:0] dbl;
    s = pt;
    for (int r = 0; r < NUM_ROUNDS; r++) begin
      s   = s ^ key;
      dbl = {s, s} >> (32 - ROT_AMOUNT);  // Rotate left via doubled word
      s   = dbl[31:0];
      s   = s + ROUND_CONST * word_t'(r + 1);
    end
    return s ^ key;  // Output whitening
  endfunction

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("FAILED at time %0t: %s is 0x%08h, expected 0x%08h",
               $time, name, actual, expected);
      $display("Errors found");
      $fatal(1, "Stopped at first mismatch");
    end
  endtask

  task automatic add_row(input op_t op, input word_t data, input logic arm, input int dly);
    stim_t row;
    row.op        = op;
    row.data      = data;
    row.arm       = arm;
    row.ack_delay = dly;
    row.exp_data  = '0;
    row.exp_trig  = 0;
    stim_q.push_back(row);
  endtask

  ////////////////////
  // Stimulus table
  ////////////////////
  task automatic build_table();
    logic [31:0] rnd;
    word_t       key;
    stim_t       row;
    rng_state = 32'h39d9_6d13;
    add_row(OP_BLOCK, 32'h0123_4567, 1'b1, 0);   // Zero key after reset
    add_row(OP_BLOCK, 32'h89ab_cdef, 1'b0, 1);   // Trigger disarmed
    add_row(OP_KEY,   32'hdead_beef, 1'b0, 0);
    add_row(OP_BLOCK, 32'h0000_0000, 1'b1, 0);
    add_row(OP_BLOCK, 32'hffff_ffff, 1'b1, 3);
    add_row(OP_KEY,   32'h0f1e_2d3c, 1'b0, 0);   // Lands while a block runs
    add_row(OP_BLOCK, 32'h1357_9bdf, 1'b1, 40);  // Long hold for back-pressure
    add_row(OP_BLOCK, 32'h2468_ace0, 1'b1, 0);
    add_row(OP_BLOCK, 32'hcafe_f00d, 1'b1, 0);   // Waits on busy
    add_row(OP_BLOCK, 32'h5a5a_a5a5, 1'b0, 2);
    for (int n = 0; n < 14; n++) begin
      rnd = next_random();
      add_row((rnd[30:28] == 3'd0) ? OP_KEY : OP_BLOCK, next_random(), rnd[16],
              int'(rnd[3:0]));
    end
    key = '0;
    foreach (stim_q[i]) begin
      row = stim_q[i];
      if (row.op == OP_KEY) begin
        key = row.data;  // Key in force for later blocks
      end else begin
        row.exp_data = encrypt_ref(key, row.data);
        row.exp_trig = row.arm ? NUM_ROUNDS : 0;
      end
      stim_q[i] = row;
    end
  endtask

  ////////////////////
  // Host models
  ////////////////////
  task automatic send_command(input op_t op, input word_t data, output int rcv_at_ack);
    @(posedge clk_main);
    host_req  <= 1'b1;
    host_op   <= op;
    host_data <= data;
    do @(negedge clk_main); while (!host_ack);
    rcv_at_ack = n_rcv;  // Results out when the ack rose
    @(posedge clk_main);
    host_req <= 1'b0;
    do @(negedge clk_main); while (host_ack);
  endtask

  task automatic run_sender();
    int rcv_at_ack;
    for (int i = 0; i < stim_q.size(); i++) begin
      if (stim_q[i].op == OP_BLOCK && stim_q[i].arm !== trig_arm) begin
        wait (n_rcv == n_acc);  // Rounds of earlier blocks over
        @(posedge clk_main);
        trig_arm <= stim_q[i].arm;
      end
      send_command(stim_q[i].op, stim_q[i].data, rcv_at_ack);
      if (stim_q[i].op == OP_BLOCK) begin
        check_value("results out at host_ack_o", rcv_at_ack, n_acc);
        n_acc++;
      end
    end
  endtask

  task automatic run_receiver();
    for (int i = 0; i < stim_q.size(); i++) begin
      if (stim_q[i].op == OP_BLOCK) begin
        do @(negedge clk_main); while (!res_req);
        n_rcv++;
        check_value("res_data_o", res_data, stim_q[i].exp_data);
        check_value("trig_o cycles", trig_cnt, stim_q[i].exp_trig);
        trig_cnt = 0;
        repeat (stim_q[i].ack_delay) begin
          @(negedge clk_main);
          check_value("res_req_o", 32'(res_req), 32'd1);  // Held under back-pressure
        end
        @(posedge clk_main);
        res_ack <= 1'b1;
        do @(negedge clk_main); while (res_req);
        // Ack kept high a little after req falls
        repeat (stim_q[i].ack_delay % 3) begin
          @(negedge clk_main);
          check_value("res_req_o", 32'(res_req), 32'd0);  // No new req before ack falls
        end
        @(posedge clk_main);
        res_ack <= 1'b0;
      end
    end
  endtask

  always @(negedge clk_main) begin
    if (trig === 1'b1) trig_cnt = trig_cnt + 1;
  end

  // Bound assertion monitor
  always @(negedge clk_main) begin
    if (UUT.u_sva.fail_cnt != 0) begin
      $display("A bound assertion on the handshakes or the trigger failed");
      $display("Errors found");
      $fatal(1, "Assertion failure");
    end
  end

  ////////////////////
  // Main sequence
  ////////////////////
  initial begin
    host_req    <= 1'b0;
    host_op     <= OP_KEY;
    host_data   <= '0;
    res_ack     <= 1'b0;
    trig_arm    <= 1'b0;
    n_acc       = 0;
    n_rcv       = 0;
    trig_cnt    = 0;
    table_ready = 1'b0;
    build_table();
    table_ready = 1'b1;
    wait (arst_n === 1'b1);
    @(negedge clk_main);
    check_value("host_ack_o", 32'(host_ack), 32'd0);  // Idle after reset
    check_value("res_req_o", 32'(res_req), 32'd0);
    check_value("trig_o", 32'(trig), 32'd0);
    fork
      run_sender();
      run_receiver();
    join
    @(negedge clk_main);  // Assertions on the last edge settle
    if (UUT.u_sva.fail_cnt != 0) begin
      $display("Bound assertions failed %0d times", UUT.u_sva.fail_cnt);
      $display("Errors found");
      $fatal(1, "Assertion failures");
    end else begin
      $display("No errors");
      $finish;
    end
  end

  initial begin : watchdog
    int limit;
    wait (table_ready === 1'b1);
    limit = stim_q.size() * (NUM_ROUNDS + 40) + 50;
    repeat (limit) @(posedge clk_main);
    $display("Timeout: the handshakes did not finish within %0d clock cycles", limit);
    $display("Errors found");
    $fatal(1, "Watchdog expired");
  end

endmodule : capture_target_tb

`default_nettype wire

//--- tests/clock_gen.sv
// Testbench clock and reset source
// 100 ns clock, reset held low for the first 10 rising edges
`timescale 1ns/1ps
`default_nettype none

module clock_gen (
  output logic clk_o,
  output logic arst_n_o
);

  initial begin
    clk_o    = 1'b0;
    arst_n_o <= 1'b0;             // Reset from time zero
    repeat (10) @(posedge clk_o);
    arst_n_o <= 1'b1;             // Released on a rising edge
  end

  always #50 clk_o = ~clk_o;      // 100 ns period

endmodule : clock_gen

`default_nettype wire
